// File: Makefile
# Verilator build and run for the ALU cluster testbench

VERILATOR ?= verilator
TOP       ?= alu_cluster_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "run ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/alu_cluster.sv
`timescale 1ns/1ps

module alu_cluster (
  input  logic             clk,
  input  logic             arst_n,
  // operation in
  input  logic             in_valid,
  output logic             in_ready,
  input  alu_pkg::ctx_t    in_ctx,
  input  alu_pkg::alu_op_t in_op,
  input  logic             in_use_carry,
  input  logic             in_no_wr,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  // result out
  output logic             out_valid,
  input  logic             out_ready,
  output alu_pkg::ctx_t    out_ctx,
  output alu_pkg::word_t   out_result,
  output alu_pkg::flags_t  out_flags
);
  import alu_pkg::*;

  alu_req_if req [num_lanes-1:0] ();
  alu_rsp_if rsp [num_lanes-1:0] ();

  op_dispatch u_dispatch (
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_ctx       (in_ctx),
    .in_op        (in_op),
    .in_use_carry (in_use_carry),
    .in_no_wr     (in_no_wr),
    .in_a         (in_a),
    .in_b         (in_b),
    .req          (req)
  );

  // one lane per context
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    alu_lane u_lane (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req[i]),
      .rsp    (rsp[i])
    );
  end

  result_merge u_merge (
    .clk        (clk),
    .arst_n     (arst_n),
    .rsp        (rsp),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_ctx    (out_ctx),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

endmodule

// File: logic/alu_if.sv
`timescale 1ns/1ps

// dispatcher to lane
interface alu_req_if;
  import alu_pkg::*;

  logic    valid;
  logic    ready;
  alu_op_t op;
  logic    use_carry;  // take stored cf as carry-in
  logic    no_wr;      // leave stored flags alone
  word_t   a;
  word_t   b;

  modport src (output valid, op, use_carry, no_wr, a, b, input ready);
  modport dst (input valid, op, use_carry, no_wr, a, b, output ready);
endinterface

// lane to merge stage
interface alu_rsp_if;
  import alu_pkg::*;

  logic   valid;
  logic   ready;
  word_t  result;
  flags_t flags;

  modport src (output valid, result, flags, input ready);
  modport dst (input valid, result, flags, output ready);
endinterface

// File: logic/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
  input logic    clk,
  input logic    arst_n,
  alu_req_if.dst req,
  alu_rsp_if.src rsp
);
  import alu_pkg::*;

  flags_t status_q;  // context status register
  logic   full_q;
  word_t  result_q;
  flags_t flags_q;

  logic          accept;
  logic          drain;
  logic          carry_in;
  logic [word_w:0] sum;
  logic [word_w:0] diff;
  logic [2*word_w-1:0] prod;
  word_t         quot;
  word_t         res;
  logic          cf;
  logic          of_bit;
  flags_t        new_flags;
  flags_t        next_flags;

  // ~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~

  assign carry_in = req.use_carry & status_q[flag_cf];

  assign sum  = {1'b0, req.a} + {1'b0, req.b} + {{word_w{1'b0}}, carry_in};
  assign diff = {1'b0, req.a} - {1'b0, req.b} - {{word_w{1'b0}}, carry_in};  // bit 32 is borrow
  assign prod = {{word_w{1'b0}}, req.a} * {{word_w{1'b0}}, req.b};
  assign quot = (req.b == '0) ? '1 : req.a / req.b;

  always_comb begin
    res    = '0;
    cf     = 1'b0;
    of_bit = 1'b0;
    case (req.op)
      op_add: begin
        res    = sum[word_w-1:0];
        cf     = sum[word_w];
        of_bit = (req.a[word_w-1] == req.b[word_w-1]) && (res[word_w-1] != req.a[word_w-1]);
      end
      op_sub: begin
        res    = diff[word_w-1:0];
        cf     = diff[word_w];
        of_bit = (req.a[word_w-1] != req.b[word_w-1]) && (res[word_w-1] != req.a[word_w-1]);
      end
      op_and: res = req.a & req.b;
      op_or:  res = req.a | req.b;
      op_xor: res = req.a ^ req.b;
      op_mul: begin
        res    = prod[word_w-1:0];
        cf     = |prod[2*word_w-1:word_w];  // product did not fit
        of_bit = cf;
      end
      op_div: res = quot;
      default: res = '0;
    endcase
  end

  always_comb begin
    new_flags          = '0;
    new_flags[flag_cf] = cf;
    new_flags[flag_pf] = ~^res[7:0];
    new_flags[flag_zf] = (res == '0);
    new_flags[flag_sf] = res[word_w-1];
    new_flags[flag_of] = of_bit;
  end

  assign next_flags = req.no_wr ? status_q : new_flags;

  // ~~~~~~~~~~~~~~~~~~~~
  // handshake and state
  // ~~~~~~~~~~~~~~~~~~~~

  assign drain     = full_q & rsp.ready;
  assign req.ready = ~full_q | rsp.ready;  // empty or emptying this cycle
  assign accept    = req.valid & req.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q   <= 1'b0;
      status_q <= '0;
    end else begin
      if (accept) begin
        full_q   <= 1'b1;
        status_q <= next_flags;
      end else if (drain) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_q <= res;
      flags_q  <= next_flags;
    end
  end

  assign rsp.valid  = full_q;
  assign rsp.result = result_q;
  assign rsp.flags  = flags_q;

  // a stalled response holds until the merge stage takes it
  a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.result) && $stable(rsp.flags));

  // an op waiting on a busy lane must hold still
  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    req.valid && !req.ready |=> req.valid && $stable(req.op) && $stable(req.a)
      && $stable(req.b) && $stable(req.use_carry) && $stable(req.no_wr));

endmodule

// File: logic/alu_pkg.sv
package alu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // cluster shape
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int num_lanes = 4;  // one lane per context
  localparam int word_w = 32;
  localparam int flag_count = 5;

  // ~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [word_w-1:0] word_t;
  typedef logic [$clog2(num_lanes)-1:0] ctx_t;
  typedef logic [flag_count-1:0] flags_t;

  // bit positions inside flags_t
  localparam int flag_cf = 0;  // carry / borrow
  localparam int flag_pf = 1;  // even parity of low byte
  localparam int flag_zf = 2;
  localparam int flag_sf = 3;
  localparam int flag_of = 4;  // signed overflow

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_mul = 3'd5,
    op_div = 3'd6  // unsigned only
  } alu_op_t;

endpackage

// File: logic/op_dispatch.sv
`timescale 1ns/1ps

module op_dispatch (
  input  logic             in_valid,
  output logic             in_ready,
  input  alu_pkg::ctx_t    in_ctx,
  input  alu_pkg::alu_op_t in_op,
  input  logic             in_use_carry,
  input  logic             in_no_wr,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  alu_req_if.src           req [alu_pkg::num_lanes-1:0]
);
  import alu_pkg::*;

  logic [num_lanes-1:0] lane_sel;    // one-hot valid
  logic [num_lanes-1:0] lane_ready;

  always_comb begin
    lane_sel = '0;
    lane_sel[in_ctx] = in_valid;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // per-lane fan-out
  // ~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign req[i].valid     = lane_sel[i];
    assign req[i].op        = in_op;  // payload goes to every lane
    assign req[i].use_carry = in_use_carry;
    assign req[i].no_wr     = in_no_wr;
    assign req[i].a         = in_a;
    assign req[i].b         = in_b;
    assign lane_ready[i]    = req[i].ready;
  end

  // only the addressed context can stall the source
  assign in_ready = lane_ready[in_ctx];

  // a valid op must name a real context, or the wrong lane gets it
  always_comb begin
    if (in_valid) begin
      assert (!$isunknown(in_ctx))
        else $error("op_dispatch: in_ctx unknown while in_valid is high");
    end
  end

endmodule

// File: logic/result_merge.sv
`timescale 1ns/1ps

module result_merge (
  input  logic            clk,
  input  logic            arst_n,
  alu_rsp_if.dst          rsp [alu_pkg::num_lanes-1:0],
  output logic            out_valid,
  input  logic            out_ready,
  output alu_pkg::ctx_t   out_ctx,
  output alu_pkg::word_t  out_result,
  output alu_pkg::flags_t out_flags
);
  import alu_pkg::*;

  logic [num_lanes-1:0] lane_valid;
  logic [num_lanes-1:0] grant;
  word_t                lane_result [num_lanes];
  flags_t               lane_flags [num_lanes];
  ctx_t                 ptr_q;  // highest priority lane
  ctx_t                 grant_idx;
  logic                 grant_any;
  logic                 can_load;
  logic                 full_q;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign lane_valid[i]  = rsp[i].valid;
    assign lane_result[i] = rsp[i].result;
    assign lane_flags[i]  = rsp[i].flags;
    assign rsp[i].ready   = grant[i];
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // round-robin arbiter
  // ~~~~~~~~~~~~~~~~~~~~

  assign can_load = ~full_q | out_ready;

  always_comb begin
    int unsigned idx;
    grant     = '0;
    grant_idx = ptr_q;
    grant_any = 1'b0;
    for (int k = 0; k < num_lanes; k++) begin
      idx = (int'(ptr_q) + k) % num_lanes;
      if (can_load && !grant_any && lane_valid[idx]) begin
        grant[idx] = 1'b1;
        grant_idx  = ctx_t'(idx);
        grant_any  = 1'b1;
      end
    end
  end

  // output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
      ptr_q  <= '0;
    end else begin
      if (grant_any) begin
        full_q <= 1'b1;
        ptr_q  <= (grant_idx == ctx_t'(num_lanes - 1)) ? '0 : grant_idx + 1'b1;
      end else if (out_ready) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_any) begin
      out_ctx    <= grant_idx;  // lane index is the context
      out_result <= lane_result[grant_idx];
      out_flags  <= lane_flags[grant_idx];
    end
  end

  assign out_valid = full_q;

  a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant));

endmodule

// File: sim/alu_checker.sv
`timescale 1ns/1ps

module alu_checker (
  input  logic             clk,
  input  logic             arst_n,
  input  string            test_name,
  input  logic             in_valid,
  input  logic             in_ready,
  input  alu_pkg::ctx_t    in_ctx,
  input  alu_pkg::alu_op_t in_op,
  input  logic             in_use_carry,
  input  logic             in_no_wr,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  input  logic             out_valid,
  input  logic             out_ready,
  input  alu_pkg::ctx_t    out_ctx,
  input  alu_pkg::word_t   out_result,
  input  alu_pkg::flags_t  out_flags,
  output int               err_count,
  output int               pending
);
  import alu_pkg::*;

  typedef logic [word_w+flag_count-1:0] beat_t;  // {result, flags}

  flags_t model_flags [num_lanes];
  beat_t  exp_q [num_lanes][$];

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic beat_t expect_op(alu_op_t op, logic cin, word_t a, word_t b);
    longint unsigned ua;
    longint unsigned ub;
    longint unsigned u;
    longint          s;
    word_t           r;
    flags_t          f;
    ua = {32'b0, a};
    ub = {32'b0, b};
    f  = '0;
    r  = '0;
    case (op)
      op_add: begin
        u = ua + ub + {63'b0, cin};
        s = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
        r = u[31:0];
        f[flag_cf] = u > 64'h0000_0000_ffff_ffff;
        f[flag_of] = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      end
      op_sub: begin
        u = ua - ub - {63'b0, cin};
        s = longint'($signed(a)) - longint'($signed(b)) - longint'(cin);
        r = u[31:0];
        f[flag_cf] = ua < (ub + {63'b0, cin});  // borrow out
        f[flag_of] = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      end
      op_and: r = a & b;
      op_or:  r = a | b;
      op_xor: r = a ^ b;
      op_mul: begin
        u = ua * ub;
        r = u[31:0];
        f[flag_cf] = u[63:32] != 32'b0;
        f[flag_of] = f[flag_cf];
      end
      op_div: r = (b == 32'b0) ? 32'hffff_ffff : a / b;
      default: r = '0;
    endcase
    f[flag_pf] = ~^r[7:0];
    f[flag_zf] = r == 32'b0;
    f[flag_sf] = r[31];
    return {r, f};
  endfunction

  initial begin
    err_count = 0;
    pending   = 0;
    for (int i = 0; i < num_lanes; i++) model_flags[i] = '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // compare
  // ~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    beat_t exp;
    logic  cin;
    if (arst_n && in_valid && in_ready) begin
      cin = in_use_carry & model_flags[in_ctx][flag_cf];
      exp = expect_op(in_op, cin, in_a, in_b);
      if (in_no_wr)
        exp[flag_count-1:0] = model_flags[in_ctx];  // held flags go out
      else
        model_flags[in_ctx] = exp[flag_count-1:0];
      exp_q[in_ctx].push_back(exp);
      pending++;
    end
    if (arst_n && out_valid && out_ready) begin
      if (exp_q[out_ctx].size() == 0) begin
        $display("checker [%s]: context %0d returned a result that was never issued",
                 test_name, out_ctx);
        err_count++;
      end else begin
        exp = exp_q[out_ctx].pop_front();
        pending--;
        if (exp != {out_result, out_flags}) begin
          $display("** Error [%s] ctx %0d: expected result %h flags %b, actual result %h flags %b",
                   test_name, out_ctx, exp[word_w+flag_count-1:flag_count],
                   exp[flag_count-1:0], out_result, out_flags);
          err_count++;
        end
      end
    end
  end

endmodule

// File: sim/alu_cluster_tb.sv
`timescale 1ns/1ps

module alu_cluster_tb;
  import alu_pkg::*;

  localparam int ops_per_test = 200;
  localparam int num_tests    = 6;

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  logic    in_ready;
  ctx_t    in_ctx;
  alu_op_t in_op;
  logic    in_use_carry;
  logic    in_no_wr;
  word_t   in_a;
  word_t   in_b;
  logic    out_valid;
  logic    out_ready;
  ctx_t    out_ctx;
  word_t   out_result;
  flags_t  out_flags;

  string cur_test;
  logic  bp_mode;  // random out_ready
  int    err_count;
  int    pending;
  int    tests_passed;
  int    tests_failed;

  alu_cluster dut0 (.*);

  alu_checker chk0 (.test_name(cur_test), .*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // every op gets 20 cycles, plus slack for reset and drain
  initial begin
    repeat (num_tests * ops_per_test * 20 + 200) @(posedge clk);
    $display("watchdog: run did not finish in time, the DUT hung or responses were lost");
    $display("Simulation failed");
    $finish;
  end

  always @(posedge clk) begin
    #1;
    out_ready = bp_mode ? ($urandom_range(0, 99) >= 30) : 1'b1;
  end

  function automatic word_t pick_word();
    case ($urandom_range(0, 9))
      0: return 32'h0000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h7fff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h0000_0001;
      default: return $urandom();
    endcase
  endfunction

  function automatic alu_op_t pick_op(int lo, int hi);
    case ($urandom_range(lo, hi))
      0: return op_add;
      1: return op_sub;
      2: return op_and;
      3: return op_or;
      4: return op_xor;
      5: return op_mul;
      default: return op_div;
    endcase
  endfunction

  // holds the op until the lane takes it
  task automatic send_op(alu_op_t op, logic uc, logic nw, word_t a, word_t b);
    in_valid     = 1'b1;
    in_ctx       = ctx_t'($urandom_range(0, num_lanes - 1));
    in_op        = op;
    in_use_carry = uc;
    in_no_wr     = nw;
    in_a         = a;
    in_b         = b;
    do @(posedge clk); while (!in_ready);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic run_test(int idx, string name);
    int      base;
    int      errs;
    alu_op_t op;
    word_t   a;
    word_t   b;
    logic    nw;
    base     = err_count;
    cur_test = name;
    bp_mode  = (idx == 6);
    for (int n = 0; n < ops_per_test; n++) begin
      a  = pick_word();
      b  = pick_word();
      nw = 1'b0;
      case (idx)
        1: op = op_add;
        2: op = op_sub;
        3: op = pick_op(2, 4);
        4: begin
          op = pick_op(5, 6);
          if ($urandom_range(0, 1) != 0) begin
            a = a & 32'h0000_ffff;  // product fits in 32 bits
            b = b & 32'h0000_ffff;
          end
          if ($urandom_range(0, 5) == 0) b = '0;
        end
        5: begin
          op = pick_op(0, 6);
          nw = $urandom_range(0, 1) != 0;
        end
        default: begin
          op = pick_op(0, 6);
          nw = $urandom_range(0, 3) == 0;
        end
      endcase
      send_op(op, $urandom_range(0, 1) != 0, nw, a, b);
    end
    @(negedge clk);
    while (pending != 0) @(negedge clk);
    errs = err_count - base;
    $display("test %0d %-13s %0d ops, %0d errors: %s", idx, name, ops_per_test, errs,
             (errs == 0) ? "pass" : "FAIL");
    if (errs == 0) tests_passed++;
    else tests_failed++;
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(32'h6e0b));
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_ctx       = '0;
    in_op        = op_add;
    in_use_carry = 1'b0;
    in_no_wr     = 1'b0;
    in_a         = '0;
    in_b         = '0;
    out_ready    = 1'b1;
    bp_mode      = 1'b0;
    cur_test     = "reset";
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;
    run_test(1, "add_carry");
    run_test(2, "sub_borrow");
    run_test(3, "logic_flags");
    run_test(4, "mul_div");
    run_test(5, "flag_hold");
    run_test(6, "back_pressure");
    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: src.f
logic/alu_pkg.sv
logic/alu_if.sv
logic/op_dispatch.sv
logic/alu_lane.sv
logic/result_merge.sv
logic/alu_cluster.sv
sim/alu_checker.sv
sim/alu_cluster_tb.sv
